/* logic/udp_pkg.sv */
// UDP/IP header fields as carried between the receive and transmit sides.
// Only addressing, ports and length are kept. Checksum and IP options are not.
`default_nettype none

package udp_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field in bytes, header included
    typedef logic [15:0] udp_len_t;

    // 112-bit header bundle, length in the top bits and source IP in the bottom
    typedef struct packed {
        udp_len_t  length;
        udp_port_t dest_port;
        udp_port_t source_port;
        ip_addr_t  dest_ip;
        ip_addr_t  source_ip;
    } udp_hdr_t;

endpackage

`default_nettype wire

/* logic/stream_pkg.sv */
// Payload stream beat layout and sizing of the echo data path.
// One beat is one 64-bit word with byte enables, end-of-frame and a user bit.
`default_nettype none

package stream_pkg;

    // One payload word
    typedef logic [63:0] beat_data_t;

    // Byte enables, one per data byte
    typedef logic [7:0] beat_keep_t;

    // 74-bit payload beat
    typedef struct packed {
        beat_data_t data;
        beat_keep_t keep;
        logic       last;
        logic       user;
    } payload_beat_t;

    // Small on purpose so back-pressure shows up quickly
    localparam int PAYLOAD_FIFO_DEPTH = 16;

    // LED bank width, also the number of payload bits shown
    localparam int LED_WIDTH = 8;

endpackage

`default_nettype wire

/* logic/udp_hdr_swap.sv */
// One-entry header stage that turns a received UDP header into its reply.
// Length passes through unchanged; local_ip is expected to be static.
`timescale 1ns/1ns
`default_nettype none

module udp_hdr_swap (
    input  wire                 clk,
    input  wire                 rst,
    input  wire udp_pkg::ip_addr_t local_ip,

    input  wire udp_pkg::udp_hdr_t rx_hdr,
    input  wire                 rx_hdr_valid,
    output logic                rx_hdr_ready,

    output udp_pkg::udp_hdr_t   tx_hdr,
    output logic                tx_hdr_valid,
    input  wire                 tx_hdr_ready
);

    import udp_pkg::*;

    udp_hdr_t reply;
    udp_hdr_t hdr_q;
    logic     full_q;
    logic     accept;

    // Slot is free, or the held header leaves on this edge
    assign rx_hdr_ready = !full_q || tx_hdr_ready;
    assign accept       = rx_hdr_valid && rx_hdr_ready;

    assign tx_hdr_valid = full_q;
    assign tx_hdr       = hdr_q;

    // Reply goes back to the sender from our own address
    always_comb begin
        reply.source_ip   = local_ip;
        reply.dest_ip     = rx_hdr.source_ip;
        reply.source_port = rx_hdr.dest_port;
        reply.dest_port   = rx_hdr.source_port;
        reply.length      = rx_hdr.length;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (tx_hdr_ready) begin
            // Drained with nothing new behind it
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hdr_q <= reply;
        end
    end

endmodule

`default_nettype wire

/* logic/udp_payload_fifo.sv */
// Synchronous FIFO for payload beats, DEPTH must be a power of two, 2 or more.
// Writing while full is blocked by in_ready, which depends on the count only.
`timescale 1ns/1ns
`default_nettype none

module udp_payload_fifo #(
    parameter int DEPTH = stream_pkg::PAYLOAD_FIFO_DEPTH
) (
    input  wire                       clk,
    input  wire                       rst,

    input  wire stream_pkg::payload_beat_t in_beat,
    input  wire                       in_valid,
    output logic                      in_ready,

    output stream_pkg::payload_beat_t out_beat,
    output logic                      out_valid,
    input  wire                       out_ready
);

    import stream_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);
    localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(DEPTH);

    payload_beat_t     mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              wr_en;
    logic              rd_en;

    assign in_ready  = count != FULL_COUNT;
    assign out_valid = count != '0;

    // Head entry straight from the storage registers
    assign out_beat  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + ADDR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + ADDR_W'(1);
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10: count <= count + (ADDR_W + 1)'(1);
                2'b01: count <= count - (ADDR_W + 1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/echo_led.sv */
// Shows the low byte of the first beat of the latest outgoing frame.
// The first beat after reset counts as a frame start.
`timescale 1ns/1ns
`default_nettype none

module echo_led (
    input  wire                          clk,
    input  wire                          rst,
    input  wire stream_pkg::payload_beat_t tx_beat,
    input  wire                          tx_beat_valid,
    input  wire                          tx_beat_ready,
    output logic [stream_pkg::LED_WIDTH-1:0] led
);

    import stream_pkg::*;

    logic in_frame;
    logic xfer;

    assign xfer = tx_beat_valid && tx_beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (xfer) begin
            // Frame start when no frame is open
            if (!in_frame) begin
                led <= tx_beat.data[LED_WIDTH-1:0];
            end
            in_frame <= !tx_beat.last;
        end
    end

endmodule

`default_nettype wire

/* logic/udp_echo_core.sv */
// UDP echo engine: reply header and FIFO-buffered payload back to the sender.
// Header and payload streams are independent; nothing pairs them up.
`timescale 1ns/1ns
`default_nettype none

module udp_echo_core (
    input  wire                          clk,
    input  wire                          rst,
    input  wire udp_pkg::ip_addr_t       local_ip,

    // Received header and payload
    input  wire udp_pkg::udp_hdr_t       rx_hdr,
    input  wire                          rx_hdr_valid,
    output logic                         rx_hdr_ready,
    input  wire stream_pkg::payload_beat_t rx_beat,
    input  wire                          rx_beat_valid,
    output logic                         rx_beat_ready,

    // Reply header and payload
    output udp_pkg::udp_hdr_t            tx_hdr,
    output logic                         tx_hdr_valid,
    input  wire                          tx_hdr_ready,
    output stream_pkg::payload_beat_t    tx_beat,
    output logic                         tx_beat_valid,
    input  wire                          tx_beat_ready,

    output logic [stream_pkg::LED_WIDTH-1:0] led
);

    udp_hdr_swap swap0 (
        .clk          (clk),
        .rst          (rst),
        .local_ip     (local_ip),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready)
    );

    udp_payload_fifo #(
        .DEPTH (stream_pkg::PAYLOAD_FIFO_DEPTH)
    ) fifo0 (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (rx_beat),
        .in_valid  (rx_beat_valid),
        .in_ready  (rx_beat_ready),
        .out_beat  (tx_beat),
        .out_valid (tx_beat_valid),
        .out_ready (tx_beat_ready)
    );

    // Watches the same tx_beat handshake seen outside
    echo_led led0 (
        .clk           (clk),
        .rst           (rst),
        .tx_beat       (tx_beat),
        .tx_beat_valid (tx_beat_valid),
        .tx_beat_ready (tx_beat_ready),
        .led           (led)
    );

endmodule

`default_nettype wire

/* dv/udp_echo_core_props.sv */
// Handshake and reset properties for the UDP echo core, attached by bind.
// Payload occupancy is tracked here from the rx and tx beat handshakes.
`timescale 1ns/1ns
`default_nettype none

module udp_echo_core_props (
    input wire                          clk,
    input wire                          rst,
    input wire udp_pkg::udp_hdr_t       tx_hdr,
    input wire                          tx_hdr_valid,
    input wire                          tx_hdr_ready,
    input wire stream_pkg::payload_beat_t tx_beat,
    input wire                          tx_beat_valid,
    input wire                          tx_beat_ready,
    input wire                          rx_beat_valid,
    input wire                          rx_beat_ready
);

    import stream_pkg::*;

    logic rx_xfer;
    logic tx_xfer;
    int   occupancy;

    assign rx_xfer = rx_beat_valid && rx_beat_ready;
    assign tx_xfer = tx_beat_valid && tx_beat_ready;

    // Beats held in the FIFO as seen from outside
    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(rx_xfer) - int'(tx_xfer);
        end
    end

    // Stalled header must stay put
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else $error("tx_hdr dropped or changed while stalled");

    beat_hold: assert property (@(posedge clk) disable iff (rst)
        tx_beat_valid && !tx_beat_ready |=> tx_beat_valid && $stable(tx_beat))
        else $error("tx_beat dropped or changed while stalled");

    reset_idle: assert property (@(posedge clk)
        rst |=> !tx_hdr_valid && !tx_beat_valid)
        else $error("output valid high right after reset");

    fifo_room: assert property (@(posedge clk) disable iff (rst)
        occupancy < PAYLOAD_FIFO_DEPTH |-> rx_beat_ready)
        else $error("rx_beat_ready low with room in the FIFO");

endmodule

bind udp_echo_core udp_echo_core_props props0 (
    .clk           (clk),
    .rst           (rst),
    .tx_hdr        (tx_hdr),
    .tx_hdr_valid  (tx_hdr_valid),
    .tx_hdr_ready  (tx_hdr_ready),
    .tx_beat       (tx_beat),
    .tx_beat_valid (tx_beat_valid),
    .tx_beat_ready (tx_beat_ready),
    .rx_beat_valid (rx_beat_valid),
    .rx_beat_ready (rx_beat_ready)
);

`default_nettype wire

/* dv/udp_echo_core_tb.sv */
// Random traffic through the echo core, checked against a queue model.
// Inputs change 1 ns after the rising edge; transfers are sampled on the edge.
`timescale 1ns/1ns
`default_nettype none

module udp_echo_core_tb;

    import udp_pkg::*;
    import stream_pkg::*;

    localparam int LIMIT = 200;
    localparam int FRAMES = 60;

    logic clk;
    logic rst;
    ip_addr_t local_ip;
    udp_hdr_t rx_hdr;
    logic rx_hdr_valid;
    logic rx_hdr_ready;
    payload_beat_t rx_beat;
    logic rx_beat_valid;
    logic rx_beat_ready;
    udp_hdr_t tx_hdr;
    logic tx_hdr_valid;
    logic tx_hdr_ready;
    payload_beat_t tx_beat;
    logic tx_beat_valid;
    logic tx_beat_ready;
    logic [LED_WIDTH-1:0] led;

    integer seed = 74075;
    int errors = 0;
    int checks = 0;
    // 0 random, 1 held low, 2 held high
    int ready_mode = 0;
    int stall_cnt = 0;
    udp_hdr_t hdr_q[$];
    payload_beat_t beat_q[$];
    logic [LED_WIDTH-1:0] exp_led = '0;
    logic frame_open = 1'b0;

    udp_echo_core dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("checks=%0d errors=%0d", checks, errors + 1);
        $display("sim failed");
        $finish;
    endtask

    function automatic payload_beat_t random_beat(input logic last);
        payload_beat_t b;
        b.data = {$random(seed), $random(seed)};
        b.keep = 8'($random(seed));
        b.last = last;
        b.user = 1'($random(seed));
        return b;
    endfunction

    function automatic udp_hdr_t random_hdr();
        udp_hdr_t h;
        h.source_ip = $random(seed);
        h.dest_ip = $random(seed);
        h.source_port = 16'($random(seed));
        h.dest_port = 16'($random(seed));
        h.length = 16'($random(seed));
        return h;
    endfunction

    // Drive a header and hold it until the core takes it
    task automatic send_hdr(input udp_hdr_t h);
        int n;
        n = 0;
        rx_hdr = h;
        rx_hdr_valid = 1'b1;
        @(posedge clk);
        while (!rx_hdr_ready) begin
            n++;
            if (n > LIMIT) abort_on_timeout("rx_hdr_ready");
            @(posedge clk);
        end
        #1 rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input payload_beat_t b);
        int n;
        n = 0;
        rx_beat = b;
        rx_beat_valid = 1'b1;
        @(posedge clk);
        while (!rx_beat_ready) begin
            n++;
            if (n > LIMIT) abort_on_timeout("rx_beat_ready");
            @(posedge clk);
        end
        #1 rx_beat_valid = 1'b0;
    endtask

    task automatic idle_gap();
        repeat ($unsigned($random(seed)) % 3) @(posedge clk);
        #1;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (hdr_q.size() != 0 || beat_q.size() != 0 || tx_hdr_valid || tx_beat_valid) begin
            n++;
            if (n > LIMIT) abort_on_timeout("the outputs to drain");
            @(posedge clk);
        end
        #1;
    endtask

    // Output ready with occasional 40-cycle stalls
    initial begin
        logic [31:0] r;
        tx_hdr_ready = 1'b0;
        tx_beat_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            r = $random(seed);
            if (ready_mode == 1) begin
                tx_hdr_ready = 1'b0;
                tx_beat_ready = 1'b0;
            end else if (ready_mode == 2) begin
                tx_hdr_ready = 1'b1;
                tx_beat_ready = 1'b1;
            end else if (stall_cnt > 0) begin
                stall_cnt--;
                tx_hdr_ready = 1'b0;
                tx_beat_ready = 1'b0;
            end else begin
                if (r[5:0] == 6'd0) stall_cnt = 40;
                tx_hdr_ready = r[8] | r[9];
                tx_beat_ready = r[10] | r[11];
            end
        end
    end

    // Model fills on input transfers and compares on output transfers
    always @(posedge clk) begin
        udp_hdr_t h;
        payload_beat_t b;
        if (!rst) begin
            checks++;
            if (led !== exp_led) begin
                report_fail($sformatf("led %h, expected %h", led, exp_led));
            end
            if (rx_hdr_valid && rx_hdr_ready) begin
                h.source_ip = local_ip;
                h.dest_ip = rx_hdr.source_ip;
                h.source_port = rx_hdr.dest_port;
                h.dest_port = rx_hdr.source_port;
                h.length = rx_hdr.length;
                hdr_q.push_back(h);
            end
            if (rx_beat_valid && rx_beat_ready) beat_q.push_back(rx_beat);
            if (tx_hdr_valid && tx_hdr_ready) begin
                checks++;
                if (hdr_q.size() == 0) begin
                    report_fail("tx_hdr transfer with no header expected");
                end else begin
                    h = hdr_q.pop_front();
                    if (tx_hdr !== h) begin
                        report_fail($sformatf("tx_hdr %h, expected %h", tx_hdr, h));
                    end
                end
            end
            if (tx_beat_valid && tx_beat_ready) begin
                checks++;
                if (beat_q.size() == 0) begin
                    report_fail("tx_beat transfer with no beat expected");
                end else begin
                    b = beat_q.pop_front();
                    if (tx_beat !== b) begin
                        report_fail($sformatf("tx_beat %h, expected %h", tx_beat, b));
                    end
                    // First beat after a last opens a new frame
                    if (!frame_open) exp_led = b.data[LED_WIDTH-1:0];
                    frame_open = !b.last;
                end
            end
        end
    end

    initial begin
        int accepted;
        int n;
        logic done;
        rst = 1'b1;
        local_ip = 32'h0a00_0107;
        rx_hdr = '0;
        rx_hdr_valid = 1'b0;
        rx_beat = '0;
        rx_beat_valid = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        checks++;
        if (tx_hdr_valid !== 1'b0 || tx_beat_valid !== 1'b0 || led !== '0) begin
            report_fail("outputs not idle after reset");
        end

        // Header and payload streams run side by side
        fork
            for (int f = 0; f < FRAMES; f++) begin
                send_hdr(random_hdr());
                idle_gap();
            end
            for (int f = 0; f < FRAMES; f++) begin
                n = 1 + ($unsigned($random(seed)) % 6);
                for (int i = 0; i < n; i++) begin
                    send_beat(random_beat(i == n - 1));
                    idle_gap();
                end
            end
        join
        ready_mode = 2;
        wait_drained();

        // FIFO fill with the output stalled, the refused beat stays offered
        ready_mode = 1;
        @(posedge clk);
        #1;
        accepted = 0;
        done = 1'b0;
        rx_beat = random_beat(1'b0);
        rx_beat_valid = 1'b1;
        while (!done) begin
            @(posedge clk);
            if (rx_beat_ready) begin
                accepted++;
                if (accepted > LIMIT) abort_on_timeout("rx_beat_ready to fall");
                #1 rx_beat = random_beat(accepted % 5 == 4);
            end else begin
                done = 1'b1;
                #1;
            end
        end
        checks++;
        if (accepted != PAYLOAD_FIFO_DEPTH) begin
            report_fail($sformatf("%0d beats accepted while stalled, expected %0d",
                                  accepted, PAYLOAD_FIFO_DEPTH));
        end

        // Header stage with the output stalled
        accepted = 0;
        rx_hdr = random_hdr();
        rx_hdr_valid = 1'b1;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (rx_hdr_ready) begin
                accepted++;
                #1 rx_hdr = random_hdr();
            end else begin
                #1;
            end
        end
        checks++;
        if (accepted != 1) begin
            report_fail($sformatf("%0d headers accepted while stalled, expected 1", accepted));
        end

        // Held header and beat must go through once ready returns
        ready_mode = 2;
        fork
            send_hdr(rx_hdr);
            send_beat(rx_beat);
        join
        wait_drained();

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* udp_echo_core.f */
logic/udp_pkg.sv
logic/stream_pkg.sv
logic/udp_hdr_swap.sv
logic/udp_payload_fifo.sv
logic/echo_led.sv
logic/udp_echo_core.sv
dv/udp_echo_core_props.sv
dv/udp_echo_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= udp_echo_core_tb
FLIST     ?= udp_echo_core.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD)
